//--- arbiter/packetTimer.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module packetTimer
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`LEN_WIDTH-1:0] length,
  input  wire logic                  run,
  output logic                       timesUp
);

  logic [`LEN_WIDTH-1:0] count;

  // the first granted cycle sees count 0 because run was low before it
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (!run)
      count <= '0;
    else
      count <= count + 1'b1;
  end

  assign timesUp = (count == length);

endmodule

`default_nettype wire

//--- arbiter/roundArbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module roundArbiter
  import arbPkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`NUM_PORTS-1:0] req,
  input  wire logic [`LEN_WIDTH-1:0] lenL,
  input  wire logic [`LEN_WIDTH-1:0] lenN,
  input  wire logic [`LEN_WIDTH-1:0] lenE,
  input  wire logic [`LEN_WIDTH-1:0] lenW,
  input  wire logic [`LEN_WIDTH-1:0] lenS,
  output arbState_t                  grant
);

  arbState_t             nextState;
  portIdx_t              holder;
  logic                  holding;
  logic [`NUM_PORTS-1:0] runTimer;
  logic [`NUM_PORTS-1:0] timesUp;
  logic [`LEN_WIDTH-1:0] lenVec [`NUM_PORTS];

  assign lenVec[PORT_L] = lenL;
  assign lenVec[PORT_N] = lenN;
  assign lenVec[PORT_E] = lenE;
  assign lenVec[PORT_W] = lenW;
  assign lenVec[PORT_S] = lenS;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genTimer
    packetTimer timer_i (
      .clk     (clk),
      .rst     (rst),
      .length  (lenVec[p]),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  assign holder  = grantPort(grant);
  assign holding = |grant[`NUM_PORTS:1];

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= ARB_IDLE;
    else
      grant <= nextState;
  end

  always_comb
  begin
    int unsigned start;
    int unsigned idx;
    logic        found;

    nextState = ARB_IDLE;
    runTimer  = '0;
    found     = 1'b0;
    start     = 0;
    idx       = 0;

    if (holding && req[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1; // holder keeps the output and its timer runs on
      nextState        = grant;
    end
    else
    begin
      // a holder scans from the port after itself, idle scans from L
      if (holding)
        start = int'(holder) + 1;
      for (int k = 0; k < `NUM_PORTS; k++)
      begin
        idx = start + k;
        if (idx >= `NUM_PORTS)
          idx = idx - `NUM_PORTS;
        // the last step of a holder's scan is the holder itself, which only wins from idle
        if (!found && req[idx] && !(holding && k == `NUM_PORTS - 1))
        begin
          found     = 1'b1;
          nextState = arbState_t'(6'b1 << (idx + 1));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- common/arbPkg.sv
`default_nettype none
`include "router_settings.svh"

package arbPkg;

  // bit 0 is idle, bits 1 to 5 are L, N, E, W, S
  typedef logic [`NUM_PORTS:0] arbState_t;

  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portIdx_t;

  localparam arbState_t ARB_IDLE = 6'b000001;

  // maps a one-hot grant to its port, idle falls back to L
  function automatic portIdx_t grantPort(arbState_t g);
    portIdx_t p;
    p = PORT_L;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (g[i + 1])
        p = portIdx_t'(i);
    end
    return p;
  endfunction

endpackage

`default_nettype wire

//--- common/flitPkg.sv
`default_nettype none
`include "router_settings.svh"

package flitPkg;

  typedef struct packed {
    logic [`FLIT_ID_WIDTH-1:0] flitId;
    logic                      spare;
    logic [`LEN_WIDTH-1:0]     length; // quota is length+1 cycles of grant
  } headView_t;

  typedef struct packed {
    logic [`FLIT_ID_WIDTH-1:0]             flitId;
    logic [`FLIT_WIDTH-`FLIT_ID_WIDTH-1:0] payload;
  } bodyView_t;

  // the id field lines up in both views, so it can be read through either one
  typedef union packed {
    headView_t headView;
    bodyView_t bodyView;
  } flitWord_t;

endpackage

`default_nettype wire

//--- common/router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

`define NUM_PORTS     5
`define FLIT_WIDTH    16
`define LEN_WIDTH     12
`define FLIT_ID_WIDTH 3

// id codes sit in the top bits of every flit
`define FLIT_HEAD 3'd1
`define FLIT_BODY 3'd2

`endif

//--- compile.f
+incdir+common
common/flitPkg.sv
common/arbPkg.sv
verilog/flitDecoder.sv
arbiter/packetTimer.sv
arbiter/roundArbiter.sv
verilog/switchCrossbar.sv
verilog/routerOutputStage.sv
verif/tb_routerOutputStage.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_routerOutputStage \
  -o simRouter && ./obj_dir/simRouter > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "simulation passed" \
  || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

//--- verif/tb_routerOutputStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module tb_routerOutputStage
  import flitPkg::*;
  import arbPkg::*;
();

  localparam int MAX_CYCLES = 2000; // the six tests take about 380 cycles together

  logic                  clk = 1'b0;
  logic                  rst;
  flitWord_t             inFlit [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inValid;
  flitWord_t             outFlit;
  logic                  outValid;
  arbState_t             grant;
  logic [`NUM_PORTS-1:0] mReq; // model view of the registered requests and flits
  flitWord_t             mFlit [`NUM_PORTS];
  logic [`LEN_WIDTH-1:0] mLen [`NUM_PORTS];
  int                    mHold = -1; // owning port or -1 while the output is free
  int                    mCount = 0;
  bit                    modelOn;
  int                    cycleCount = 0;
  logic [15:0]           lfsr;

  routerOutputStage dut_i (
    .clk      (clk),
    .rst      (rst),
    .inLFlit  (inFlit[PORT_L]),
    .inNFlit  (inFlit[PORT_N]),
    .inEFlit  (inFlit[PORT_E]),
    .inWFlit  (inFlit[PORT_W]),
    .inSFlit  (inFlit[PORT_S]),
    .inLValid (inValid[PORT_L]),
    .inNValid (inValid[PORT_N]),
    .inEValid (inValid[PORT_E]),
    .inWValid (inValid[PORT_W]),
    .inSValid (inValid[PORT_S]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  always #20 clk = ~clk;

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compareSignal(input string name, input logic [15:0] got,
                               input logic [15:0] want);
    assert (got === want)
    else
      failRun($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, want));
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES)
      failRun($sformatf("timeout after %0d cycles with the tests still running", MAX_CYCLES));
  end

  function automatic flitWord_t headFlit(input logic [`LEN_WIDTH-1:0] len);
    flitWord_t f;
    f.headView = '{flitId: `FLIT_HEAD, spare: 1'b0, length: len};
    return f;
  endfunction

  function automatic flitWord_t bodyFlit(input logic [12:0] data);
    flitWord_t f;
    f.bodyView = '{flitId: `FLIT_BODY, payload: data};
    return f;
  endfunction

  function automatic arbState_t portGrant(input int p);
    arbState_t g;
    g = '0;
    g[p + 1] = 1'b1;
    return g;
  endfunction

  // Galois LFSR with taps 0xB400 that steps once for each bit it hands out
  function automatic logic [15:0] randomBits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return bits;
  endfunction

  task automatic drivePort(input int p, input logic valid, input flitWord_t f);
    inValid[p] <= valid;
    inFlit[p]  <= f;
  endtask

  task automatic waitForGrant(input int p);
    do
      @(negedge clk);
    while (grant !== portGrant(p));
  endtask

  task automatic releaseInputs();
    @(posedge clk);
    inValid <= '0;
    repeat (4) @(posedge clk);
  endtask

  // the inputs seen on the falling edge are what the next rising edge samples
  always @(negedge clk)
  begin
    int nextHold;
    int cand;
    if (modelOn)
    begin
      compareSignal("grant", 16'(grant), (mHold < 0) ? 16'(ARB_IDLE) : 16'(portGrant(mHold)));
      compareSignal("outValid", 16'(outValid), 16'(mHold >= 0 && mReq[mHold]));
      compareSignal("outFlit", outFlit, (mHold < 0) ? 16'h0 : 16'(mFlit[mHold]));
    end
    nextHold = -1;
    if (mHold >= 0 && mReq[mHold] && mCount != mLen[mHold])
      nextHold = mHold; // quota of length+1 cycles not used up yet
    else
      for (int k = 1; k < `NUM_PORTS + (mHold < 0); k++)
      begin
        cand = (mHold + k) % `NUM_PORTS; // idle starts at L and a holder at the port after it
        if (nextHold < 0 && mReq[cand])
          nextHold = cand;
      end
    mCount = (!rst && nextHold >= 0 && nextHold == mHold) ? mCount + 1 : 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (rst)
        mLen[p] = '0;
      else if (mReq[p] && mFlit[p].headView.flitId == `FLIT_HEAD)
        mLen[p] = mFlit[p].headView.length;
      mFlit[p] = rst ? flitWord_t'(0) : inFlit[p];
    end
    mReq  = rst ? '0 : inValid;
    mHold = rst ? -1 : nextHold;
  end

  task automatic resetIdle();
    repeat (4)
    begin
      @(negedge clk);
      compareSignal("grant", 16'(grant), 16'(ARB_IDLE));
      compareSignal("outValid", 16'(outValid), 16'd0);
    end
  endtask

  task automatic singleHeader();
    logic [12:0] payload [3];
    payload = '{13'h0a5, 13'h1234, 13'h0f0f};
    @(posedge clk);
    drivePort(PORT_N, 1'b1, headFlit(12'd3));
    for (int i = 0; i < 4; i++)
    begin
      @(posedge clk);
      if (i < 3)
        drivePort(PORT_N, 1'b1, bodyFlit(payload[i]));
      else
        inValid[PORT_N] <= 1'b0;
      @(negedge clk);
      if (i > 0)
      begin
        compareSignal("grant", 16'(grant), 16'(portGrant(PORT_N)));
        compareSignal("outValid", 16'(outValid), 16'd1);
        compareSignal("outFlit.payload", 16'(outFlit.bodyView.payload), 16'(payload[i - 1]));
      end
    end
    releaseInputs();
  endtask

  task automatic quotaRotate();
    @(posedge clk);
    drivePort(PORT_L, 1'b1, headFlit(12'd2));
    drivePort(PORT_E, 1'b1, headFlit(12'd4));
    @(posedge clk);
    drivePort(PORT_L, 1'b1, bodyFlit(13'h11));
    drivePort(PORT_E, 1'b1, bodyFlit(13'h22));
    waitForGrant(PORT_L);
    for (int c = 0; c < 16; c++)
    begin
      // 3 cycles of L then 5 of E
      compareSignal("grant", 16'(grant), 16'(portGrant((c % 8 < 3) ? PORT_L : PORT_E)));
      @(negedge clk);
    end
    releaseInputs();
  endtask

  task automatic rotationOrder();
    @(posedge clk);
    for (int p = 0; p < `NUM_PORTS; p++)
      drivePort(p, 1'b1, headFlit(12'd0));
    waitForGrant(PORT_L);
    for (int c = 0; c < 10; c++)
    begin
      compareSignal("grant", 16'(grant), 16'(portGrant(c % `NUM_PORTS)));
      @(negedge clk);
    end
    releaseInputs();
  endtask

  task automatic dropRequest();
    int held;
    held = 0;
    @(posedge clk);
    for (int p = PORT_L; p <= PORT_E; p++)
      drivePort(p, 1'b1, headFlit(12'd7));
    waitForGrant(PORT_L);
    @(posedge clk);
    inValid[PORT_L] <= 1'b0;
    // the drop reaches req one edge later and grant the edge after that
    do
    begin
      @(negedge clk);
      held++;
    end
    while (grant === portGrant(PORT_L));
    compareSignal("cycles until handover", 16'(held), 16'd3);
    compareSignal("grant", 16'(grant), 16'(portGrant(PORT_N)));
    @(posedge clk);
    inValid[PORT_N] <= 1'b0;
    inValid[PORT_E] <= 1'b0;
    repeat (3) @(negedge clk);
    compareSignal("grant", 16'(grant), 16'(ARB_IDLE)); // nobody left to rotate to
    releaseInputs();
  endtask

  task automatic randomTraffic();
    logic        isHead;
    logic        valid;
    logic [15:0] field;
    for (int c = 0; c < 300; c++)
    begin
      @(posedge clk);
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        isHead = randomBits(1) != 0;
        valid  = randomBits(1) != 0;
        if (isHead)
          field = randomBits(3);
        else
          field = randomBits(8);
        drivePort(p, valid, isHead ? headFlit(12'(field)) : bodyFlit(13'(field)));
      end
    end
    releaseInputs();
  endtask

  initial
  begin
    modelOn = 1'b0;
    lfsr    = 16'd46;
    rst     <= 1'b1;
    inValid <= '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlit[p] <= '0;
    repeat (2) @(posedge clk);
    rst     <= 1'b0;
    modelOn = 1'b1;
    resetIdle();
    singleHeader();
    quotaRotate();
    rotationOrder();
    dropRequest();
    randomTraffic();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/flitDecoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module flitDecoder
  import flitPkg::*;
(
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire flitWord_t           inFlit,
  input  wire logic                inValid,
  output logic                     req,
  output logic [`FLIT_ID_WIDTH-1:0] flitId,
  output logic [`LEN_WIDTH-1:0]    pktLength,
  output flitWord_t                flitReg
);

  // the request simply follows valid one cycle later
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      req     <= 1'b0;
      flitReg <= '0;
    end
    else
    begin
      req     <= inValid;
      flitReg <= inFlit;
    end
  end

  // length is taken from the registered header, so it lands one cycle after the flit
  always_ff @(posedge clk)
  begin
    if (rst)
      pktLength <= '0;
    else if (req && flitReg.headView.flitId == `FLIT_HEAD)
      pktLength <= flitReg.headView.length;
  end

  assign flitId = flitReg.bodyView.flitId;

endmodule

`default_nettype wire

//--- verilog/routerOutputStage.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module routerOutputStage
  import flitPkg::*;
  import arbPkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,
  input  wire flitWord_t inLFlit,
  input  wire flitWord_t inNFlit,
  input  wire flitWord_t inEFlit,
  input  wire flitWord_t inWFlit,
  input  wire flitWord_t inSFlit,
  input  wire logic      inLValid,
  input  wire logic      inNValid,
  input  wire logic      inEValid,
  input  wire logic      inWValid,
  input  wire logic      inSValid,
  output flitWord_t      outFlit,
  output logic           outValid,
  output arbState_t      grant
);

  flitWord_t             inFlit    [`NUM_PORTS];
  flitWord_t             flitReg   [`NUM_PORTS];
  logic [`LEN_WIDTH-1:0] pktLength [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inValid;
  logic [`NUM_PORTS-1:0] req;

  assign inFlit[PORT_L] = inLFlit;
  assign inFlit[PORT_N] = inNFlit;
  assign inFlit[PORT_E] = inEFlit;
  assign inFlit[PORT_W] = inWFlit;
  assign inFlit[PORT_S] = inSFlit;
  assign inValid = {inSValid, inWValid, inEValid, inNValid, inLValid};

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : genDecoder
    flitDecoder decoder_i (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inFlit[p]),
      .inValid   (inValid[p]),
      .req       (req[p]),
      .flitId    (),          // id is already inside the registered flit
      .pktLength (pktLength[p]),
      .flitReg   (flitReg[p])
    );
  end

  roundArbiter arbiter_i (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .lenL (pktLength[PORT_L]),
    .lenN (pktLength[PORT_N]),
    .lenE (pktLength[PORT_E]),
    .lenW (pktLength[PORT_W]),
    .lenS (pktLength[PORT_S]),
    .grant (grant)
  );

  // registered valid is the request itself
  switchCrossbar crossbar_i (
    .grant    (grant),
    .flitL    (flitReg[PORT_L]),
    .flitN    (flitReg[PORT_N]),
    .flitE    (flitReg[PORT_E]),
    .flitW    (flitReg[PORT_W]),
    .flitS    (flitReg[PORT_S]),
    .validVec (req),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

//--- verilog/switchCrossbar.sv
`timescale 1ns/1ns
`default_nettype none
`include "router_settings.svh"

module switchCrossbar
  import flitPkg::*;
  import arbPkg::*;
(
  input  wire arbState_t             grant,
  input  wire flitWord_t             flitL,
  input  wire flitWord_t             flitN,
  input  wire flitWord_t             flitE,
  input  wire flitWord_t             flitW,
  input  wire flitWord_t             flitS,
  input  wire logic [`NUM_PORTS-1:0] validVec,
  output flitWord_t                  outFlit,
  output logic                       outValid
);

  flitWord_t flitVec [`NUM_PORTS];
  portIdx_t  sel;

  assign flitVec[PORT_L] = flitL;
  assign flitVec[PORT_N] = flitN;
  assign flitVec[PORT_E] = flitE;
  assign flitVec[PORT_W] = flitW;
  assign flitVec[PORT_S] = flitS;

  assign sel = grantPort(grant);

  always_comb
  begin
    if (grant == ARB_IDLE)
    begin
      outFlit  = '0; // nobody owns the channel
      outValid = 1'b0;
    end
    else
    begin
      outFlit  = flitVec[sel];
      outValid = validVec[sel];
    end
  end

endmodule

`default_nettype wire
